/* flist.f */
hw/bitsyncPkg.sv
hw/bitsyncRegs.sv
hw/dcOffsetLoop.sv
hw/ambiguityResolver.sv
hw/dacMonitorSelect.sv
hw/bitsyncBackEnd.sv
verification/bitsyncBackEnd_chk.sv
verification/bitsyncBackEndTb.sv

/* hw/ambiguityResolver.sv */
// QPSK/OQPSK phase ambiguity resolution.
// In the dual modes the i/q decision pair is rotated by the 2-bit
// rotation input on each ch0 symbol strobe. Offset QPSK uses the q bit
// from the previous symbol in the quarter turns. Otherwise each
// channel's bit is registered on its own strobe.
`timescale 1ns/1ps

module ambiguityResolver (
    input  logic                     clk,
    input  logic                     rst,
    input  bitsyncPkg::bitsyncMode_t mode,
    input  logic [1:0]               rotation,
    input  bitsyncPkg::symStream_t   sym0,
    input  bitsyncPkg::symStream_t   sym1,
    output logic                     ch0Bit,
    output logic                     ch1Bit
);

    import bitsyncPkg::*;

    logic iBit;
    logic qBit;
    logic qDelay;
    logic qTurn;
    logic rot0Bit;
    logic rot1Bit;

    assign iBit = sym0.hardBit;
    assign qBit = sym1.hardBit;

    // offset qpsk lags q by half a symbol.
    assign qTurn = (mode == MODE_OFFSET) ? qDelay : qBit;

    always_comb begin
        case (rotation)
            2'd0: begin
                rot0Bit = iBit;
                rot1Bit = qBit;
            end
            2'd1: begin
                rot0Bit = qTurn;
                rot1Bit = ~iBit;
            end
            2'd2: begin
                rot0Bit = ~iBit;
                rot1Bit = ~qBit;
            end
            default: begin
                rot0Bit = ~qTurn;
                rot1Bit = iBit;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ch0Bit <= 1'b0;
            ch1Bit <= 1'b0;
            qDelay <= 1'b0;
        end else if (mode == MODE_DUAL || mode == MODE_OFFSET) begin
            if (sym0.symEn) begin
                ch0Bit <= rot0Bit;
                ch1Bit <= rot1Bit;
                if (mode == MODE_OFFSET) begin
                    qDelay <= qBit;
                end
            end
        end else begin
            if (sym0.symEn) begin
                ch0Bit <= sym0.hardBit;
            end
            if (sym1.symEn) begin
                ch1Bit <= sym1.hardBit;
            end
        end
    end

endmodule

/* hw/bitsyncBackEnd.sv */
// Two-channel PCM bit synchronizer back end.
// Control registers, DC offset loops, ambiguity resolution and the DAC
// monitor outputs. In the synchronous modes the ch1 loop and monitors
// follow the ch0 double-rate strobe.
`timescale 1ns/1ps

module bitsyncBackEnd (
    input  logic                   clk,
    input  logic                   rst,
    input  bitsyncPkg::busReq_t    busReq,
    input  bitsyncPkg::rxSample_t  rx0,
    input  bitsyncPkg::rxSample_t  rx1,
    input  bitsyncPkg::symStream_t sym0,
    input  bitsyncPkg::symStream_t sym1,
    input  logic [1:0]             rotation,
    output bitsyncPkg::busData_t   dout,
    output logic                   asyncMode,
    output bitsyncPkg::sample_t    ch0Offset,
    output bitsyncPkg::sample_t    ch1Offset,
    output logic                   ch0Bit,
    output logic                   ch1Bit,
    output bitsyncPkg::dacOut_t    ch0Dac0,
    output bitsyncPkg::dacOut_t    ch0Dac1,
    output bitsyncPkg::dacOut_t    ch0Dac2,
    output bitsyncPkg::dacOut_t    ch1Dac0,
    output bitsyncPkg::dacOut_t    ch1Dac1,
    output bitsyncPkg::dacOut_t    ch1Dac2,
    output logic                   ch0HighImpedance,
    output logic                   ch0SingleEnded,
    output logic                   ch1HighImpedance,
    output logic                   ch1SingleEnded
);

    import bitsyncPkg::*;

    bitsyncMode_t   mode;
    chConfig_t      ch0Cfg;
    chConfig_t      ch1Cfg;
    logic           ch1DcEn;
    symStream_t     sym1Mon;
    dacOut_t [2:0]  ch0Dac;
    dacOut_t [2:0]  ch1Dac;

    bitsyncRegs u_regs (
        .clk    (clk),
        .rst    (rst),
        .busReq (busReq),
        .dout   (dout),
        .mode   (mode),
        .ch0Cfg (ch0Cfg),
        .ch1Cfg (ch1Cfg)
    );

    assign asyncMode = (mode == MODE_IND) || (mode == MODE_SINGLE);

    // ch1 runs on its own strobe only when the channels are independent.
    assign ch1DcEn = asyncMode ? sym1.sym2xEn : sym0.sym2xEn;

    always_comb begin
        sym1Mon         = sym1;
        sym1Mon.sym2xEn = ch1DcEn;
    end

    dcOffsetLoop u_ch0Dc (
        .clk(clk), .rst(rst), .stepEn(sym0.sym2xEn),
        .sample(rx0.sample), .cfg(ch0Cfg), .offset(ch0Offset)
    );

    dcOffsetLoop u_ch1Dc (
        .clk(clk), .rst(rst), .stepEn(ch1DcEn),
        .sample(rx1.sample), .cfg(ch1Cfg), .offset(ch1Offset)
    );

    ambiguityResolver u_ambiguity (
        .clk(clk), .rst(rst), .mode(mode), .rotation(rotation),
        .sym0(sym0), .sym1(sym1), .ch0Bit(ch0Bit), .ch1Bit(ch1Bit)
    );

    // three monitor DACs per channel.
    for (genvar k = 0; k < 3; k++) begin : g_dac
        dacMonitorSelect u_ch0Mon (
            .clk(clk), .rst(rst), .sel(ch0Cfg.dacSel[k]), .rx(rx0),
            .dcOffset(ch0Offset), .dcEn(sym0.sym2xEn), .sym(sym0), .dac(ch0Dac[k])
        );
        dacMonitorSelect u_ch1Mon (
            .clk(clk), .rst(rst), .sel(ch1Cfg.dacSel[k]), .rx(rx1),
            .dcOffset(ch1Offset), .dcEn(ch1DcEn), .sym(sym1Mon), .dac(ch1Dac[k])
        );
    end

    assign ch0Dac0 = ch0Dac[0];
    assign ch0Dac1 = ch0Dac[1];
    assign ch0Dac2 = ch0Dac[2];
    assign ch1Dac0 = ch1Dac[0];
    assign ch1Dac1 = ch1Dac[1];
    assign ch1Dac2 = ch1Dac[2];

    // analog front end controls.
    assign ch0HighImpedance = ch0Cfg.highImpedance;
    assign ch0SingleEnded   = ch0Cfg.singleEnded;
    assign ch1HighImpedance = ch1Cfg.highImpedance;
    assign ch1SingleEnded   = ch1Cfg.singleEnded;

endmodule

/* hw/bitsyncPkg.sv */
// Bit synchronizer back end shared definitions.
// Sample and loop widths, mode and DAC monitor encodings, the register map
// and the packed structs that carry the bus and symbol streams.
package bitsyncPkg;

    typedef logic signed [17:0] sample_t;
    typedef logic signed [39:0] dcAccum_t;
    typedef logic [4:0]         dcGain_t;
    typedef logic [7:0]         dcTest_t;
    typedef logic [12:0]        busAddr_t;
    typedef logic [31:0]        busData_t;

    // monitor sources, undefined codes fall back to the raw sample.
    typedef enum logic [3:0] {
        DAC_ADC = 4'd0,
        DAC_DC  = 4'd1,
        DAC_SYM = 4'd3
    } dacSel_t;

    typedef enum logic [1:0] {
        MODE_DUAL   = 2'd0,
        MODE_OFFSET = 2'd1,
        MODE_IND    = 2'd2,
        MODE_SINGLE = 2'd3
    } bitsyncMode_t;

    // word address of the register block, low two bits are the index.
    localparam logic [10:0] REGS_BASE = 11'h040;
    localparam logic [1:0]  REG_MODE  = 2'd0;
    localparam logic [1:0]  REG_CH0   = 2'd1;
    localparam logic [1:0]  REG_CH1   = 2'd2;

    // channel configuration word layout.
    localparam int DAC_SEL_LSB    = 0;
    localparam int DC_EN_BIT      = 12;
    localparam int HIGH_Z_BIT     = 13;
    localparam int SINGLE_END_BIT = 14;
    localparam int DC_GAIN_LSB    = 16;
    localparam int DC_TEST_LSB    = 24;

    localparam int DC_TEST_SHIFT = 10;
    localparam int DC_IN_SHIFT   = 16;

    typedef struct packed {
        busAddr_t addr;
        logic     wr0;
        logic     wr1;
        logic     wr2;
        logic     wr3;
        busData_t data;
    } busReq_t;

    typedef struct packed {
        logic    valid;
        sample_t sample;
    } rxSample_t;

    typedef struct packed {
        logic    sym2xEn;
        logic    symEn;
        sample_t symData;
        logic    hardBit;
    } symStream_t;

    typedef struct packed {
        dacSel_t [2:0] dacSel;
        logic          dcRemovalEnable;
        logic          highImpedance;
        logic          singleEnded;
        dcGain_t       dcGain;
        dcTest_t       dcTest;
    } chConfig_t;

    typedef struct packed {
        logic    clkEn;
        sample_t data;
    } dacOut_t;

endpackage

/* hw/bitsyncRegs.sv */
// Bit synchronizer control registers.
// Mode register and one configuration register per channel on the
// processor bus, written byte by byte, with combinational readback.
// Unmapped addresses read as zero.
`timescale 1ns/1ps

module bitsyncRegs (
    input  logic                    clk,
    input  logic                    rst,
    input  bitsyncPkg::busReq_t     busReq,
    output bitsyncPkg::busData_t    dout,
    output bitsyncPkg::bitsyncMode_t mode,
    output bitsyncPkg::chConfig_t   ch0Cfg,
    output bitsyncPkg::chConfig_t   ch1Cfg
);

    import bitsyncPkg::*;

    busData_t   regFile [3];
    logic [1:0] regIdx;
    logic       regSpace;
    logic       regMapped;
    logic [3:0] byteEn;
    logic       regWrite;

    // unpacks a configuration word into its fields.
    function automatic chConfig_t toConfig(busData_t word);
        chConfig_t cfg;
        for (int k = 0; k < 3; k++) begin
            cfg.dacSel[k] = dacSel_t'(word[DAC_SEL_LSB + k*$bits(dacSel_t) +: $bits(dacSel_t)]);
        end
        cfg.dcRemovalEnable = word[DC_EN_BIT];
        cfg.highImpedance   = word[HIGH_Z_BIT];
        cfg.singleEnded     = word[SINGLE_END_BIT];
        cfg.dcGain          = word[DC_GAIN_LSB +: $bits(dcGain_t)];
        cfg.dcTest          = word[DC_TEST_LSB +: $bits(dcTest_t)];
        return cfg;
    endfunction

    // block of four words, only three of them populated.
    assign regIdx    = busReq.addr[3:2];
    assign regSpace  = (busReq.addr[12:4] == REGS_BASE[10:2]);
    assign regMapped = regSpace && (regIdx <= REG_CH1);
    assign byteEn    = {busReq.wr3, busReq.wr2, busReq.wr1, busReq.wr0};
    assign regWrite  = regMapped && (|byteEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 3; r++) begin
                regFile[r] <= '0;
            end
        end else if (regWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    regFile[regIdx][8*b +: 8] <= busReq.data[8*b +: 8];
                end
            end
        end
    end

    // readback mux.
    always_comb begin
        dout = '0;
        if (regMapped) begin
            case (regIdx)
                REG_MODE: dout = regFile[0];
                REG_CH0:  dout = regFile[1];
                REG_CH1:  dout = regFile[2];
                default:  dout = '0;
            endcase
        end
    end

    assign mode   = bitsyncMode_t'(regFile[REG_MODE][1:0]);
    assign ch0Cfg = toConfig(regFile[REG_CH0]);
    assign ch1Cfg = toConfig(regFile[REG_CH1]);

endmodule

/* hw/dacMonitorSelect.sv */
// DAC monitor source selector.
// Registers one internal signal and its strobe for a monitor DAC.
`timescale 1ns/1ps

module dacMonitorSelect (
    input  logic                   clk,
    input  logic                   rst,
    input  bitsyncPkg::dacSel_t    sel,
    input  bitsyncPkg::rxSample_t  rx,
    input  bitsyncPkg::sample_t    dcOffset,
    input  logic                   dcEn,
    input  bitsyncPkg::symStream_t sym,
    output bitsyncPkg::dacOut_t    dac
);

    import bitsyncPkg::*;

    dacOut_t dacNext;

    always_comb begin
        case (sel)
            DAC_DC: begin
                dacNext.data  = dcOffset;
                dacNext.clkEn = dcEn;
            end
            DAC_SYM: begin
                dacNext.data  = sym.symData;
                dacNext.clkEn = sym.sym2xEn;
            end
            // raw sample, also for undefined codes.
            default: begin
                dacNext.data  = rx.sample;
                dacNext.clkEn = rx.valid;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac <= '0;
        end else begin
            dac <= dacNext;
        end
    end

endmodule

/* hw/dcOffsetLoop.sv */
// DC offset removal loop for one channel.
// Integrates the incoming sample, scaled down by the configured gain
// exponent, on each step strobe. A nonzero test value overrides the
// offset estimate.
`timescale 1ns/1ps

module dcOffsetLoop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stepEn,
    input  bitsyncPkg::sample_t   sample,
    input  bitsyncPkg::chConfig_t cfg,
    output bitsyncPkg::sample_t   offset
);

    import bitsyncPkg::*;

    logic signed [$bits(sample_t)+DC_IN_SHIFT-1:0] dcIn;
    dcAccum_t dcInExt;
    dcAccum_t step;
    dcAccum_t accum;

    // sample moved up to the loop scale, then sign extended.
    assign dcIn    = {sample, {DC_IN_SHIFT{1'b0}}};
    assign dcInExt = dcIn;
    assign step    = dcInExt >>> cfg.dcGain;

    always_ff @(posedge clk) begin
        if (rst || !cfg.dcRemovalEnable) begin
            accum <= '0;
        end else if (stepEn) begin
            accum <= accum + step;
        end
    end

    // top bits of the accumulator are the estimate.
    always_comb begin
        if (cfg.dcTest != '0) begin
            offset = {cfg.dcTest, {DC_TEST_SHIFT{1'b0}}};
        end else begin
            offset = accum[$bits(dcAccum_t)-1 -: $bits(sample_t)];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the bit synchronizer back end testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module bitsyncBackEndTb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VbitsyncBackEndTb +verilator+error+limit+1000)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verification/bitsyncBackEndTb.sv */
// Testbench for the bit synchronizer back end.
// Directed tests of the register block, the DC offset loops, the QPSK and
// OQPSK ambiguity resolution and the DAC monitor selection, with models
// built from the bit-level rules of each block.
`timescale 1ns/1ps

module bitsyncBackEndTb;

    import bitsyncPkg::*;

    localparam int CYCLE_LIMIT = 2000;
    localparam logic [3:0] DAC_CODES [5] = '{4'd0, 4'd1, 4'd3, 4'd2, 4'd15};

    logic       clk = 1'b0;
    logic       rst;
    busReq_t    busReq;
    rxSample_t  rx0;
    rxSample_t  rx1;
    symStream_t sym0;
    symStream_t sym1;
    logic [1:0] rotation;
    busData_t   dout;
    logic       asyncMode;
    sample_t    ch0Offset;
    sample_t    ch1Offset;
    logic       ch0Bit;
    logic       ch1Bit;
    dacOut_t    ch0Dac0;
    dacOut_t    ch0Dac1;
    dacOut_t    ch0Dac2;
    dacOut_t    ch1Dac0;
    dacOut_t    ch1Dac1;
    dacOut_t    ch1Dac2;
    logic       ch0HighImpedance;
    logic       ch0SingleEnded;
    logic       ch1HighImpedance;
    logic       ch1SingleEnded;

    int       errors = 0;
    int       cycles = 0;
    int       assertFails;
    busData_t shadow [3];

    bitsyncBackEnd u_dut (
        .clk(clk), .rst(rst), .busReq(busReq), .rx0(rx0), .rx1(rx1),
        .sym0(sym0), .sym1(sym1), .rotation(rotation), .dout(dout),
        .asyncMode(asyncMode), .ch0Offset(ch0Offset), .ch1Offset(ch1Offset),
        .ch0Bit(ch0Bit), .ch1Bit(ch1Bit),
        .ch0Dac0(ch0Dac0), .ch0Dac1(ch0Dac1), .ch0Dac2(ch0Dac2),
        .ch1Dac0(ch1Dac0), .ch1Dac1(ch1Dac1), .ch1Dac2(ch1Dac2),
        .ch0HighImpedance(ch0HighImpedance), .ch0SingleEnded(ch0SingleEnded),
        .ch1HighImpedance(ch1HighImpedance), .ch1SingleEnded(ch1SingleEnded)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // inputs change a little after the rising edge.
    task automatic stepClk();
        @(posedge clk);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // byte address of a register, index in bits 3:2.
    function automatic busAddr_t regAddr(input logic [1:0] idx);
        return {REGS_BASE[10:2], idx, 2'b00};
    endfunction

    // DAC0 select sits in the low nibble of sels.
    function automatic busData_t cfgWord(input logic [11:0] sels, input logic dcEn,
                                         input logic hiZ, input logic se,
                                         input dcGain_t gain, input dcTest_t test);
        busData_t w;
        w = '0;
        w[11:0]           = sels;
        w[DC_EN_BIT]      = dcEn;
        w[HIGH_Z_BIT]     = hiZ;
        w[SINGLE_END_BIT] = se;
        w[DC_GAIN_LSB +: 5] = gain;
        w[DC_TEST_LSB +: 8] = test;
        return w;
    endfunction

    // one loop increment, sample scaled up then shifted down by the gain.
    function automatic dcAccum_t dcStep(input sample_t s, input dcGain_t g);
        dcAccum_t ext;
        ext = {{6{s[17]}}, s, 16'h0000};
        return ext >>> g;
    endfunction

    // returns {ch0Bit, ch1Bit}.
    function automatic logic [1:0] rotateBits(input logic [1:0] rot, input logic i,
                                              input logic q, input logic qTurn);
        case (rot)
            2'd0:    return {i, q};
            2'd1:    return {qTurn, ~i};
            2'd2:    return {~i, ~q};
            default: return {~qTurn, i};
        endcase
    endfunction

    function automatic dacOut_t dacModel(input logic [3:0] sel, input rxSample_t rx,
                                         input sample_t dcVal, input logic dcEn,
                                         input sample_t symData, input logic symStrobe);
        dacOut_t d;
        if (sel == 4'd1) begin
            d.clkEn = dcEn;
            d.data  = dcVal;
        end else if (sel == 4'd3) begin
            d.clkEn = symStrobe;
            d.data  = symData;
        end else begin
            d.clkEn = rx.valid;
            d.data  = rx.sample;
        end
        return d;
    endfunction

    task automatic busWrite(input busAddr_t addr, input busData_t data, input logic [3:0] be);
        logic [1:0] idx;
        idx = addr[3:2];
        busReq.addr = addr;
        busReq.data = data;
        {busReq.wr3, busReq.wr2, busReq.wr1, busReq.wr0} = be;
        stepClk();
        {busReq.wr3, busReq.wr2, busReq.wr1, busReq.wr0} = 4'b0000;
        if (addr[12:4] == REGS_BASE[10:2] && idx <= 2'd2) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic busCheck(input busAddr_t addr, input busData_t exp);
        busReq.addr = addr;
        #1;
        checkValue($sformatf("dout@%h", addr), dout, exp);
    endtask

    task automatic sendSymbol(input logic [1:0] rot, input logic i, input logic q);
        rotation      = rot;
        sym0.hardBit  = i;
        sym1.hardBit  = q;
        sym0.symEn    = 1'b1;
        stepClk();
        sym0.symEn    = 1'b0;
    endtask

    task automatic regsTest();
        for (int r = 0; r < 3; r++) begin
            busCheck(regAddr(2'(r)), 32'h0);
        end
        busWrite(regAddr(REG_CH0), 32'hA5C3_6BCD, 4'b0101);
        busWrite(regAddr(REG_CH1), 32'h1234_5678, 4'b1010);
        busWrite(regAddr(REG_MODE), 32'hFFFF_FFFE, 4'b1000);
        // none of these may land in the register block.
        busWrite(regAddr(2'd3), 32'hFFFF_FFFF, 4'b1111);
        busWrite(13'h0000, 32'hDEAD_BEEF, 4'b1111);
        busWrite(13'h1104, 32'h0BAD_F00D, 4'b1111);
        for (int r = 0; r < 3; r++) begin
            busCheck(regAddr(2'(r)), shadow[r]);
        end
        busCheck(regAddr(2'd3), 32'h0);
        busCheck(13'h0000, 32'h0);
        busCheck(13'h1104, 32'h0);
        for (int p = 0; p < 4; p++) begin
            busWrite(regAddr(REG_CH0), cfgWord(12'h000, 1'b0, p[0], p[1], 5'd0, 8'd0), 4'hF);
            busWrite(regAddr(REG_CH1), cfgWord(12'h000, 1'b0, p[1], p[0], 5'd0, 8'd0), 4'hF);
            checkValue("ch0HighImpedance", ch0HighImpedance, p[0]);
            checkValue("ch0SingleEnded", ch0SingleEnded, p[1]);
            checkValue("ch1HighImpedance", ch1HighImpedance, p[1]);
            checkValue("ch1SingleEnded", ch1SingleEnded, p[0]);
        end
        busWrite(regAddr(REG_CH0), 32'h0, 4'hF);
        busWrite(regAddr(REG_CH1), 32'h0, 4'hF);
    endtask

    task automatic dcLoopTest();
        dcAccum_t    acc0;
        dcAccum_t    acc1;
        sample_t     expOff;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        acc0 = '0;
        acc1 = '0;
        busWrite(regAddr(REG_CH0), cfgWord(12'h000, 1'b1, 1'b0, 1'b0, 5'd3, 8'd0), 4'hF);
        busWrite(regAddr(REG_CH1), cfgWord(12'h000, 1'b1, 1'b0, 1'b0, 5'd5, 8'd0), 4'hF);
        for (int n = 0; n < 24; n++) begin
            rnd  = $urandom;
            rnd2 = $urandom;
            rx0.sample    = rnd[17:0];
            rx1.sample    = rnd2[17:0];
            sym0.sym2xEn  = rnd[18];
            stepClk();
            // sync mode, so both loops step on the ch0 strobe.
            if (rnd[18]) begin
                acc0 = acc0 + dcStep(rnd[17:0], 5'd3);
                acc1 = acc1 + dcStep(rnd2[17:0], 5'd5);
            end
            expOff = acc0[39:22];
            checkValue("ch0Offset", ch0Offset, expOff);
            expOff = acc1[39:22];
            checkValue("ch1Offset", ch1Offset, expOff);
        end
        sym0.sym2xEn = 1'b0;
        busWrite(regAddr(REG_CH0), cfgWord(12'h000, 1'b0, 1'b0, 1'b0, 5'd3, 8'd0), 4'hF);
        stepClk();
        checkValue("ch0Offset", ch0Offset, 64'h0);
        busWrite(regAddr(REG_CH0), cfgWord(12'h000, 1'b0, 1'b0, 1'b0, 5'd3, 8'h5A), 4'hF);
        expOff = {8'h5A, 10'h000};
        checkValue("ch0Offset", ch0Offset, expOff);
        busWrite(regAddr(REG_CH0), cfgWord(12'h000, 1'b1, 1'b0, 1'b0, 5'd3, 8'hC3), 4'hF);
        expOff = {8'hC3, 10'h000};
        checkValue("ch0Offset", ch0Offset, expOff);
        busWrite(regAddr(REG_CH0), 32'h0, 4'hF);
        busWrite(regAddr(REG_CH1), 32'h0, 4'hF);
    endtask

    task automatic dualRotationTest();
        logic [31:0] rnd;
        logic [1:0]  exp;
        busWrite(regAddr(REG_MODE), 32'h0, 4'hF);
        for (int r = 0; r < 4; r++) begin
            for (int n = 0; n < 8; n++) begin
                rnd = $urandom;
                sendSymbol(2'(r), rnd[0], rnd[1]);
                exp = rotateBits(2'(r), rnd[0], rnd[1], rnd[1]);
                checkValue("ch0Bit", ch0Bit, exp[1]);
                checkValue("ch1Bit", ch1Bit, exp[0]);
                stepClk();
            end
        end
    endtask

    task automatic offsetQpskTest();
        logic [31:0] rnd;
        logic [1:0]  exp;
        logic [1:0]  rot;
        logic        qPrev;
        busWrite(regAddr(REG_MODE), 32'h1, 4'hF);
        // delayed q has been zero since reset.
        qPrev = 1'b0;
        for (int n = 0; n < 20; n++) begin
            rnd = $urandom;
            rot = {n[1], 1'b1};
            sendSymbol(rot, rnd[0], rnd[1]);
            exp   = rotateBits(rot, rnd[0], rnd[1], qPrev);
            qPrev = rnd[1];
            checkValue("ch0Bit", ch0Bit, exp[1]);
            checkValue("ch1Bit", ch1Bit, exp[0]);
            stepClk();
        end
    endtask

    task automatic independentTest();
        logic [31:0] rnd;
        logic        exp0;
        logic        exp1;
        dcAccum_t    acc1;
        sample_t     expOff;
        busWrite(regAddr(REG_MODE), 32'h2, 4'hF);
        checkValue("asyncMode", asyncMode, 64'h1);
        busWrite(regAddr(REG_CH1), cfgWord(12'h000, 1'b1, 1'b0, 1'b0, 5'd4, 8'd0), 4'hF);
        acc1 = '0;
        exp0 = 1'b0;
        exp1 = 1'b0;
        for (int n = 0; n < 24; n++) begin
            rnd = $urandom;
            sym0.symEn   = rnd[0] | (n == 0);
            sym1.symEn   = rnd[1] | (n == 0);
            sym0.hardBit = rnd[2];
            sym1.hardBit = rnd[3];
            sym0.sym2xEn = rnd[4];
            sym1.sym2xEn = rnd[5];
            rotation     = rnd[7:6];
            rx1.sample   = rnd[31:14];
            stepClk();
            if (rnd[0] || n == 0) begin
                exp0 = rnd[2];
            end
            if (rnd[1] || n == 0) begin
                exp1 = rnd[3];
            end
            if (rnd[5]) begin
                acc1 = acc1 + dcStep(rnd[31:14], 5'd4);
            end
            checkValue("ch0Bit", ch0Bit, exp0);
            checkValue("ch1Bit", ch1Bit, exp1);
            expOff = acc1[39:22];
            checkValue("ch1Offset", ch1Offset, expOff);
        end
        sym0 = '0;
        sym1 = '0;
        busWrite(regAddr(REG_CH1), 32'h0, 4'hF);
        for (int m = 0; m < 4; m++) begin
            busWrite(regAddr(REG_MODE), 32'(m), 4'hF);
            checkValue("asyncMode", asyncMode, (m >= 2));
        end
    endtask

    task automatic dacTest();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [3:0]  code [3];
        logic        ch1Strobe;
        dacOut_t     exp0 [3];
        dacOut_t     exp1 [3];
        sample_t     dcVal0;
        sample_t     dcVal1;
        dcVal0 = {8'h3C, 10'h000};
        dcVal1 = {8'h81, 10'h000};
        for (int mi = 0; mi < 2; mi++) begin
            busWrite(regAddr(REG_MODE), (mi == 1) ? 32'h2 : 32'h0, 4'hF);
            for (int ci = 0; ci < 5; ci++) begin
                // each DAC of a channel gets a different code.
                for (int k = 0; k < 3; k++) begin
                    code[k] = DAC_CODES[(ci + k) % 5];
                end
                busWrite(regAddr(REG_CH0), cfgWord({code[2], code[1], code[0]},
                                                   1'b0, 1'b0, 1'b0, 5'd0, 8'h3C), 4'hF);
                busWrite(regAddr(REG_CH1), cfgWord({code[2], code[1], code[0]},
                                                   1'b0, 1'b0, 1'b0, 5'd0, 8'h81), 4'hF);
                for (int n = 0; n < 8; n++) begin
                    rnd  = $urandom;
                    rnd2 = $urandom;
                    rx0.valid     = rnd[0];
                    rx0.sample    = rnd[18:1];
                    rx1.valid     = rnd[19];
                    rx1.sample    = rnd2[17:0];
                    sym0.sym2xEn  = rnd[20];
                    sym1.sym2xEn  = rnd[21];
                    sym0.symData  = rnd2[31:14];
                    sym1.symData  = {rnd[31:22], rnd2[7:0]};
                    // ch1 follows the ch0 double-rate strobe unless independent.
                    ch1Strobe = (mi == 1) ? rnd[21] : rnd[20];
                    for (int k = 0; k < 3; k++) begin
                        exp0[k] = dacModel(code[k], rx0, dcVal0, rnd[20], sym0.symData,
                                           rnd[20]);
                        exp1[k] = dacModel(code[k], rx1, dcVal1, ch1Strobe, sym1.symData,
                                           ch1Strobe);
                    end
                    stepClk();
                    checkValue("ch0Dac0", ch0Dac0, exp0[0]);
                    checkValue("ch0Dac1", ch0Dac1, exp0[1]);
                    checkValue("ch0Dac2", ch0Dac2, exp0[2]);
                    checkValue("ch1Dac0", ch1Dac0, exp1[0]);
                    checkValue("ch1Dac1", ch1Dac1, exp1[1]);
                    checkValue("ch1Dac2", ch1Dac2, exp1[2]);
                end
                rx0 = '0;
                rx1 = '0;
                sym0 = '0;
                sym1 = '0;
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        busReq   = '0;
        rx0      = '0;
        rx1      = '0;
        sym0     = '0;
        sym1     = '0;
        rotation = 2'd0;
        // sample strobes held high so only the reset keeps the DAC strobes low.
        rx0.valid = 1'b1;
        rx1.valid = 1'b1;
        for (int r = 0; r < 3; r++) begin
            shadow[r] = '0;
        end
        void'($urandom(73));
        repeat (3) @(posedge clk);
        #2;
        rst       = 1'b0;
        rx0.valid = 1'b0;
        rx1.valid = 1'b0;

        regsTest();
        dcLoopTest();
        dualRotationTest();
        offsetQpskTest();
        independentTest();
        dacTest();
        stepClk();
        stepClk();

        assertFails = u_dut.u_chk.failCount;
        $display("Check errors: %0d, assertion failures: %0d", errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/bitsyncBackEnd_chk.sv */
// Bound assertions for the bit synchronizer back end.
// Checks the async mode flag against writes to the mode register, when the
// resolved bits may change, and that the DAC strobes are idle after reset.
`timescale 1ns/1ps

module bitsyncBackEnd_chk (
    input logic                 clk,
    input logic                 rst,
    input bitsyncPkg::busReq_t  busReq,
    input logic                 asyncMode,
    input logic                 sym0SymEn,
    input logic                 sym1SymEn,
    input logic                 ch0Bit,
    input logic                 ch1Bit,
    input logic [5:0]           dacStrobes
);

    import bitsyncPkg::*;

    int   failCount = 0;
    logic modeWrite;

    // low byte of the mode register written.
    assign modeWrite = busReq.wr0 && (busReq.addr[12:4] == REGS_BASE[10:2])
                       && (busReq.addr[3:2] == REG_MODE);

    // independent and single are the two mode codes with bit 1 set.
    asyncModeOnWrite: assert property (@(posedge clk) disable iff (rst)
        modeWrite |=> (asyncMode == $past(busReq.data[1])))
        else begin
            failCount++;
            $error("asyncMode does not follow the written mode");
        end

    asyncModeHeld: assert property (@(posedge clk) disable iff (rst)
        !modeWrite |=> $stable(asyncMode))
        else begin
            failCount++;
            $error("asyncMode changed without a mode register write");
        end

    // ch0 always resolves on the ch0 symbol strobe.
    ch0BitOnStrobe: assert property (@(posedge clk) disable iff (rst)
        (ch0Bit != $past(ch0Bit)) |-> $past(sym0SymEn))
        else begin
            failCount++;
            $error("ch0Bit changed without a symbol strobe");
        end

    // ch1 follows its own strobe only when the channels are independent.
    ch1BitOnStrobe: assert property (@(posedge clk) disable iff (rst)
        (ch1Bit != $past(ch1Bit)) |-> $past(asyncMode ? sym1SymEn : sym0SymEn))
        else begin
            failCount++;
            $error("ch1Bit changed without a symbol strobe");
        end

    dacIdleAfterReset: assert property (@(posedge clk) rst |=> (dacStrobes == 6'b0))
        else begin
            failCount++;
            $error("DAC strobe high in the cycle after reset");
        end

endmodule

bind bitsyncBackEnd bitsyncBackEnd_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .busReq     (busReq),
    .asyncMode  (asyncMode),
    .sym0SymEn  (sym0.symEn),
    .sym1SymEn  (sym1.symEn),
    .ch0Bit     (ch0Bit),
    .ch1Bit     (ch1Bit),
    .dacStrobes ({ch0Dac0.clkEn, ch0Dac1.clkEn, ch0Dac2.clkEn,
                  ch1Dac0.clkEn, ch1Dac1.clkEn, ch1Dac2.clkEn})
);
